//--- flist.f
source/buf_pkg.sv
source/sync_fifo.sv
source/fifo_event_logger.sv
source/stream_buffer_top.sv
bench/tb_stream_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the stream buffer testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_stream_buffer -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_stream_buffer 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF "PASS: all tests" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- bench/tb_stream_buffer.sv
`timescale 1ns/1ps

module tb_stream_buffer;

    localparam int sample_depth = 8;
    localparam int sample_afull = 6;
    localparam int sample_aempty = 2;
    localparam int event_depth = 4;
    localparam int lost_max = 255;

    // the watchdog allows the cycle budgets of reset and the six tests.
    localparam int budget_cycles = 10 + 10 + 40 + 40 + 50 + 60 + 40;
    localparam int watchdog_ns = budget_cycles * 4 + 400;

    logic                         clk;
    logic                         rst_n;
    logic                         wr_en;
    logic [buf_pkg::sample_w-1:0] wr_data;
    logic                         rd_en;
    logic                         evt_rd_en;
    logic [buf_pkg::sample_w-1:0] rd_data;
    logic                         full;
    logic                         empty;
    logic                         almost_full;
    logic                         almost_empty;
    buf_pkg::evt_code_t           evt_code;
    logic [buf_pkg::time_w-1:0]   evt_time;
    logic                         evt_empty;
    logic [buf_pkg::lost_w-1:0]   lost_count;

    // reference model state.
    logic [buf_pkg::sample_w-1:0] model_q[$];
    logic [buf_pkg::sample_w-1:0] exp_rd;
    buf_pkg::evt_code_t           exp_code_q[$];
    logic [buf_pkg::time_w-1:0]   exp_time_q[$];
    int                           exp_lost;
    logic [buf_pkg::time_w-1:0]   edge_cnt;

    logic [31:0] rng_state;
    int          err_count;
    int          tests_run;
    int          tests_failed;
    string       cur_test;

    stream_buffer_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .evt_rd_en    (evt_rd_en),
        .rd_data      (rd_data),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .evt_code     (evt_code),
        .evt_time     (evt_time),
        .evt_empty    (evt_empty),
        .lost_count   (lost_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // an event stamp should read the number of rising edges since reset.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_cnt <= '0;
        end else begin
            edge_cnt <= edge_cnt + 1'b1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("ERR %0t: %s: %s", $time, cur_test, msg);
            err_count++;
        end
    endtask

    // an event goes into the log unless the log already holds event_depth records.
    task automatic log_event(input buf_pkg::evt_code_t code);
        if (exp_code_q.size() >= event_depth) begin
            if (exp_lost < lost_max) begin
                exp_lost++;
            end
        end else begin
            exp_code_q.push_back(code);
            exp_time_q.push_back(edge_cnt);
        end
    endtask

    task automatic check_outputs();
        int n;
        n = model_q.size();
        check(full == (n == sample_depth), $sformatf("full %b with %0d words", full, n));
        check(empty == (n == 0), $sformatf("empty %b with %0d words", empty, n));
        check(almost_full == (n >= sample_afull),
              $sformatf("almost_full %b with %0d words", almost_full, n));
        check(almost_empty == (n <= sample_aempty),
              $sformatf("almost_empty %b with %0d words", almost_empty, n));
        check(rd_data == exp_rd, $sformatf("rd_data %h, expected %h", rd_data, exp_rd));
    endtask

    // drives one clock cycle of stimulus on a falling edge and checks it on the next one.
    task automatic access(input logic w, input logic [buf_pkg::sample_w-1:0] d,
                          input logic r, input logic e);
        int   n;
        logic wr_ok;
        logic rd_ok;
        n = model_q.size();
        wr_ok = w && (n < sample_depth);
        rd_ok = r && (n > 0);
        wr_en = w;
        wr_data = d;
        rd_en = r;
        evt_rd_en = e;
        @(posedge clk);
        @(negedge clk);
        wr_en = 1'b0;
        rd_en = 1'b0;
        evt_rd_en = 1'b0;
        if (rd_ok) begin
            exp_rd = model_q.pop_front();
        end
        if (wr_ok) begin
            model_q.push_back(d);
        end
        if (w && !wr_ok) begin
            log_event(buf_pkg::evt_overflow);
        end
        if (r && !rd_ok) begin
            log_event(buf_pkg::evt_underflow);
        end
        if ((model_q.size() >= sample_afull) && (n < sample_afull)) begin
            log_event(buf_pkg::evt_high_water);
        end
        check_outputs();
    endtask

    task automatic write_sample();
        rng_state = xorshift(rng_state);
        access(1'b1, rng_state[buf_pkg::sample_w-1:0], 1'b0, 1'b0);
    endtask

    task automatic read_sample();
        access(1'b0, '0, 1'b1, 1'b0);
    endtask

    task automatic write_read_sample();
        rng_state = xorshift(rng_state);
        access(1'b1, rng_state[buf_pkg::sample_w-1:0], 1'b1, 1'b0);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            access(1'b0, '0, 1'b0, 1'b0);
        end
    endtask

    // reads every expected record back and checks code, stamp and ordering.
    task automatic drain_events();
        buf_pkg::evt_code_t         code;
        logic [buf_pkg::time_w-1:0] stamp;
        logic [buf_pkg::time_w-1:0] last;
        logic                       have_last;
        have_last = 1'b0;
        last = '0;
        idle(2);
        check(int'(lost_count) == exp_lost,
              $sformatf("lost_count %0d, expected %0d", lost_count, exp_lost));
        while (exp_code_q.size() > 0) begin
            check(!evt_empty, "event log empty while a record is expected");
            code = exp_code_q.pop_front();
            stamp = exp_time_q.pop_front();
            access(1'b0, '0, 1'b0, 1'b1);
            check(evt_code == code, $sformatf("event code %0d, expected %0d", evt_code, code));
            check(evt_time == stamp, $sformatf("event stamp %0d, expected %0d", evt_time, stamp));
            if (have_last) begin
                check(evt_time > last, $sformatf("stamp %0d after %0d", evt_time, last));
            end
            last = evt_time;
            have_last = 1'b1;
        end
        check(evt_empty, "event log not empty after the expected records");
    endtask

    task automatic finish_test(input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, err_count - errs_before);
        end
    endtask

    task automatic reset_state();
        int errs;
        cur_test = "reset";
        errs = err_count;
        check_outputs();
        check(evt_empty, "evt_empty low after reset");
        check(lost_count == '0, "lost_count not zero after reset");
        check(evt_time == '0, "evt_time not zero after reset");
        finish_test(errs);
    endtask

    task automatic order_and_flags();
        int errs;
        cur_test = "order_flags";
        errs = err_count;
        repeat (sample_depth) write_sample();
        repeat (sample_depth) read_sample();
        drain_events();
        finish_test(errs);
    endtask

    task automatic simultaneous_access();
        int errs;
        cur_test = "simultaneous";
        errs = err_count;
        repeat (3) write_sample();
        repeat (4) write_read_sample();
        repeat (3) read_sample();
        // on an empty FIFO only the write goes through.
        write_read_sample();
        read_sample();
        drain_events();
        finish_test(errs);
    endtask

    task automatic refusal_events();
        int errs;
        cur_test = "refusals";
        errs = err_count;
        repeat (sample_depth) write_sample();
        write_sample();
        repeat (sample_depth) read_sample();
        read_sample();
        drain_events();
        finish_test(errs);
    endtask

    task automatic event_log_order();
        int errs;
        cur_test = "event_log";
        errs = err_count;
        repeat (sample_depth) write_sample();
        write_sample();
        repeat (3) read_sample();
        // back up to the high-water level for a second crossing.
        write_sample();
        repeat (sample_afull) read_sample();
        read_sample();
        drain_events();
        finish_test(errs);
    endtask

    task automatic loss_counting();
        int errs;
        int lost_before;
        cur_test = "loss";
        errs = err_count;
        lost_before = exp_lost;
        repeat (event_depth + 3) read_sample();
        idle(2);
        check(int'(lost_count) == lost_before + 3,
              $sformatf("lost_count %0d, expected %0d", lost_count, lost_before + 3));
        drain_events();
        finish_test(errs);
    endtask

    initial begin
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_data = '0;
        rd_en = 1'b0;
        evt_rd_en = 1'b0;
        rng_state = 32'h405f_6b23;
        exp_rd = '0;
        exp_lost = 0;
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = "none";
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        order_and_flags();
        simultaneous_access();
        refusal_events();
        event_log_order();
        loss_counting();
        $display("summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- source/stream_buffer_top.sv
`timescale 1ns/1ps

module stream_buffer_top #(
    parameter int sample_depth = 8,
    parameter int sample_afull = 6,
    parameter int sample_aempty = 2,
    parameter int event_depth = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  logic [buf_pkg::sample_w-1:0]  wr_data,
    input  logic                          rd_en,
    input  logic                          evt_rd_en,
    output logic [buf_pkg::sample_w-1:0]  rd_data,
    output logic                          full,
    output logic                          empty,
    output logic                          almost_full,
    output logic                          almost_empty,
    output buf_pkg::evt_code_t            evt_code,
    output logic [buf_pkg::time_w-1:0]    evt_time,
    output logic                          evt_empty,
    output logic [buf_pkg::lost_w-1:0]    lost_count
);

    logic            samp_overflow;
    logic            samp_underflow;
    logic            log_wr;
    logic            log_full;
    buf_pkg::event_t log_data;
    buf_pkg::event_t evt_rd_data;

    sync_fifo #(
        .payload_t    (logic [buf_pkg::sample_w-1:0]),
        .depth        (sample_depth),
        .afull_level  (sample_afull),
        .aempty_level (sample_aempty)
    ) sample_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .overflow     (samp_overflow),
        .underflow    (samp_underflow)
    );

    fifo_event_logger logger (
        .clk         (clk),
        .rst_n       (rst_n),
        .overflow    (samp_overflow),
        .underflow   (samp_underflow),
        .almost_full (almost_full),
        .log_full    (log_full),
        .log_wr      (log_wr),
        .log_data    (log_data),
        .lost_count  (lost_count)
    );

    // the event log only needs full and empty; the other flags stay open.
    sync_fifo #(
        .payload_t    (buf_pkg::event_t),
        .depth        (event_depth),
        .afull_level  (event_depth),
        .aempty_level (0)
    ) event_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (log_wr),
        .wr_data      (log_data),
        .rd_en        (evt_rd_en),
        .rd_data      (evt_rd_data),
        .full         (log_full),
        .empty        (evt_empty),
        .almost_full  (),
        .almost_empty (),
        .overflow     (),
        .underflow    ()
    );

    assign evt_code = evt_rd_data.code;
    assign evt_time = evt_rd_data.stamp;

endmodule

//--- source/fifo_event_logger.sv
`timescale 1ns/1ps

module fifo_event_logger (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         overflow,
    input  logic                         underflow,
    input  logic                         almost_full,
    input  logic                         log_full,
    output logic                         log_wr,
    output buf_pkg::event_t              log_data,
    output logic [buf_pkg::lost_w-1:0]   lost_count
);

    logic [buf_pkg::time_w-1:0] stamp_cnt;
    logic                       afull_q;
    logic                       high_water;
    logic                       event_hit;
    buf_pkg::evt_code_t         code;

    // free-running cycle counter used as the timestamp, wraps silently.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stamp_cnt <= '0;
        end else begin
            stamp_cnt <= stamp_cnt + buf_pkg::time_w'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            afull_q <= 1'b0;
        end else begin
            afull_q <= almost_full;
        end
    end

    // only the crossing into almost-full is logged, not the whole stay there.
    assign high_water = almost_full && !afull_q;

    assign event_hit = overflow || underflow || high_water;

    // overflow and underflow never coincide, and high water is caused by an
    // accepted write, so the priority order only matters for safety.
    always_comb begin
        if (overflow) begin
            code = buf_pkg::evt_overflow;
        end else if (underflow) begin
            code = buf_pkg::evt_underflow;
        end else begin
            code = buf_pkg::evt_high_water;
        end
    end

    assign log_data.code  = code;
    assign log_data.stamp = stamp_cnt;

    // the record goes into the log FIFO in the detection cycle when there is room.
    assign log_wr = event_hit && !log_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lost_count <= '0;
        end else if (event_hit && log_full && (lost_count != '1)) begin
            lost_count <= lost_count + buf_pkg::lost_w'(1);
        end
    end

endmodule

//--- source/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 8,
    parameter int afull_level = depth - 1,
    parameter int aempty_level = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     full,
    output logic     empty,
    output logic     almost_full,
    output logic     almost_empty,
    output logic     overflow,
    output logic     underflow
);

    localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              wr_ok;
    logic              rd_ok;

    // a write to a full FIFO is refused even when a read happens in the same cycle.
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // all level flags come straight from the occupancy count.
    assign full         = (count == cnt_w'(depth));
    assign empty        = (count == '0);
    assign almost_full  = (count >= cnt_w'(afull_level));
    assign almost_empty = (count <= cnt_w'(aempty_level));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            if (wr_ptr == addr_w'(depth - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + addr_w'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_ok) begin
            if (rd_ptr == addr_w'(depth - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + addr_w'(1);
            end
        end
    end

    // a read and a write in the same cycle leave the count where it was.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10: count <= count + cnt_w'(1);
                2'b01: count <= count - cnt_w'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // registered read port, holds its word until the next accepted read.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // refusal pulses are high for the one cycle after the refused edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow  <= wr_en && full;
            underflow <= rd_en && empty;
        end
    end

endmodule

//--- source/buf_pkg.sv
package buf_pkg;

    // width of one stream sample.
    localparam int sample_w = 16;

    // width of the event timestamp; the counter behind it wraps.
    localparam int time_w = 12;

    // width of the saturating count of dropped event records.
    localparam int lost_w = 8;

    // event codes carried in each log record.
    typedef enum logic [1:0] {
        evt_overflow   = 2'd0,
        evt_underflow  = 2'd1,
        evt_high_water = 2'd2
    } evt_code_t;

    // one log record, code in the upper bits and the stamp below.
    typedef struct packed {
        evt_code_t          code;
        logic [time_w-1:0]  stamp;
    } event_t;

endpackage
